/* files.f */
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_memory.sv
src/rv_core.sv
tests/wb_memory_model.sv
tests/rv_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module rv_core_tb -o rv_core_sim
./obj_dir/rv_core_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
	exit 1
fi

/* tests/rv_core_tb.sv */
// runs a short program on the core against an isa model and checks commits and bus traffic
module rv_core_tb;

	localparam logic [31:0] reset_pc = 32'h0000_0100;
	localparam int prog_len = 18;
	localparam int mem_words = 512;

	logic        clk;
	logic        rst;
	logic        ibus_cyc;
	logic        ibus_stb;
	logic [31:0] ibus_adr;
	logic [31:0] ibus_dat_r;
	logic        ibus_ack;
	logic        dbus_cyc;
	logic        dbus_stb;
	logic        dbus_we;
	logic [31:0] dbus_adr;
	logic [63:0] dbus_dat_w;
	logic [7:0]  dbus_sel;
	logic [63:0] dbus_dat_r;
	logic        dbus_ack;
	logic        commit_valid;
	logic [4:0]  commit_rd;
	logic [63:0] commit_data;
	logic        halted;

	// program, memory image and expected results
	logic [31:0] prog [prog_len];
	logic [63:0] img [mem_words];
	logic [4:0]  exp_rd [$];
	logic [63:0] exp_data [$];
	int          exp_test [$];
	logic [31:0] st_adr [$];
	logic [63:0] st_data [$];
	int          exp_total;
	int          st_total;

	// bookkeeping
	int    fails [1:6];
	int    checks;
	int    commit_count;
	int    store_count;
	int    failed_tests;
	string test_name [1:6];

	// sampled copies for reset, hold and halt checks
	logic        rst_q;
	logic        i_req_q;
	logic [31:0] i_adr_q;
	logic        d_req_q;
	logic [31:0] d_adr_q;
	logic [63:0] d_dat_q;
	logic        ibus_cyc_q;
	logic        halted_q;
	logic        first_fetch;

	rv_core #(
		.reset_pc(reset_pc)
	) rv_core_i (
		.clk(clk), .rst(rst),
		.ibus_cyc(ibus_cyc), .ibus_stb(ibus_stb), .ibus_adr(ibus_adr),
		.ibus_dat_r(ibus_dat_r), .ibus_ack(ibus_ack),
		.dbus_cyc(dbus_cyc), .dbus_stb(dbus_stb), .dbus_we(dbus_we),
		.dbus_adr(dbus_adr), .dbus_dat_w(dbus_dat_w), .dbus_sel(dbus_sel),
		.dbus_dat_r(dbus_dat_r), .dbus_ack(dbus_ack),
		.commit_valid(commit_valid), .commit_rd(commit_rd),
		.commit_data(commit_data), .halted(halted)
	);

	wb_memory_model #(
		.words(mem_words)
	) mem_i (
		.clk(clk), .rst(rst),
		.ibus_cyc(ibus_cyc), .ibus_stb(ibus_stb), .ibus_adr(ibus_adr),
		.ibus_dat_r(ibus_dat_r), .ibus_ack(ibus_ack),
		.dbus_cyc(dbus_cyc), .dbus_stb(dbus_stb), .dbus_we(dbus_we),
		.dbus_adr(dbus_adr), .dbus_dat_w(dbus_dat_w), .dbus_sel(dbus_sel),
		.dbus_dat_r(dbus_dat_r), .dbus_ack(dbus_ack)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ******************************************************************
	// instruction encoders
	// ******************************************************************
	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] enc_sd(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'h23};
	endfunction

	// fill depends on every address bit
	function automatic logic [63:0] fill_word(int unsigned k);
		return {32'h9e37_79b9 * k + 32'h1234_5677, ~(k * 32'h85eb_ca6b) ^ 32'hc2b2_ae35};
	endfunction

	task automatic load_program();
		logic [31:0] a;
		begin
			prog[0]  = enc_i(12'h400, 5'd0, 3'd3, 5'd1, 7'h03);
			prog[1]  = enc_i(12'h408, 5'd0, 3'd3, 5'd2, 7'h03);
			prog[2]  = enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3);
			prog[3]  = enc_r(7'h20, 5'd1, 5'd3, 3'd0, 5'd4);
			prog[4]  = enc_r(7'h00, 5'd2, 5'd4, 3'd7, 5'd5);
			prog[5]  = enc_r(7'h00, 5'd1, 5'd5, 3'd6, 5'd6);
			prog[6]  = enc_r(7'h00, 5'd3, 5'd6, 3'd4, 5'd7);
			prog[7]  = enc_i(12'hffb, 5'd7, 3'd0, 5'd8, 7'h13);
			prog[8]  = {20'habcde, 5'd9, 7'h37};
			// write to x0 must not commit
			prog[9]  = enc_i(12'h007, 5'd8, 3'd0, 5'd0, 7'h13);
			prog[10] = enc_r(7'h00, 5'd8, 5'd9, 3'd0, 5'd9);
			prog[11] = enc_sd(12'h410, 5'd9, 5'd0);
			prog[12] = enc_sd(12'h420, 5'd3, 5'd0);
			// reads back the first store
			prog[13] = enc_i(12'h410, 5'd0, 3'd3, 5'd11, 7'h03);
			prog[14] = enc_r(7'h00, 5'd9, 5'd11, 3'd4, 5'd12);
			prog[15] = enc_i(12'hfff, 5'd0, 3'd0, 5'd13, 7'h13);
			prog[16] = 32'h0010_0073;
			prog[17] = enc_i(12'h005, 5'd0, 3'd0, 5'd14, 7'h13);
			for (int k = 0; k < mem_words; k++)
				img[k] = fill_word(k);
			for (int n = 0; n < prog_len; n++) begin
				a = reset_pc + 32'(4 * n);
				if (a[2])
					img[a[11:3]][63:32] = prog[n];
				else
					img[a[11:3]][31:0] = prog[n];
			end
			for (int k = 0; k < mem_words; k++)
				mem_i.mem[k] <= img[k];
		end
	endtask

	// ******************************************************************
	// isa model walks the program in order up to ebreak
	// ******************************************************************
	task automatic build_model();
		logic [63:0] x [32];
		logic [31:0] inst;
		logic [31:0] adr;
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [4:0]  rd;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [4:0]  prev_rd;
		logic [63:0] si;
		logic [63:0] ss;
		logic [63:0] res;
		logic        wr;
		logic        done;
		int          tid;
		begin
			for (int r = 0; r < 32; r++)
				x[r] = '0;
			done    = 1'b0;
			prev_rd = '0;
			for (int n = 0; n < prog_len && !done; n++) begin
				inst = prog[n];
				opc  = inst[6:0];
				rd   = inst[11:7];
				f3   = inst[14:12];
				ra   = inst[19:15];
				rb   = inst[24:20];
				f7   = inst[31:25];
				si   = {{52{inst[31]}}, inst[31:20]};
				ss   = {{52{inst[31]}}, inst[31:25], inst[11:7]};
				res  = '0;
				wr   = 1'b0;
				tid  = 2;
				case (opc)
				7'h13: begin
					wr  = (f3 == 3'd0);
					res = x[ra] + si;
				end
				7'h33: begin
					wr = 1'b1;
					case ({f7, f3})
					{7'h00, 3'd0}: res = x[ra] + x[rb];
					{7'h20, 3'd0}: res = x[ra] - x[rb];
					{7'h00, 3'd4}: res = x[ra] ^ x[rb];
					{7'h00, 3'd6}: res = x[ra] | x[rb];
					{7'h00, 3'd7}: res = x[ra] & x[rb];
					default: wr = 1'b0;
					endcase
				end
				7'h37: begin
					wr  = 1'b1;
					res = {{32{inst[31]}}, inst[31:12], 12'h000};
				end
				7'h03: begin
					if (f3 == 3'd3) begin
						adr = x[ra][31:0] + si[31:0];
						res = img[adr[11:3]];
						wr  = 1'b1;
						tid = 4;
					end
				end
				7'h23: begin
					if (f3 == 3'd3) begin
						adr = x[ra][31:0] + ss[31:0];
						img[adr[11:3]] = x[rb];
						st_adr.push_back(adr);
						st_data.push_back(x[rb]);
					end
				end
				7'h73: done = (inst == 32'h0010_0073);
				default: wr = 1'b0;
				endcase
				if (wr && rd != 5'd0) begin
					// reads the result of the instruction just before it
					if (tid == 2 && prev_rd != 5'd0 &&
							(ra == prev_rd || (opc == 7'h33 && rb == prev_rd)))
						tid = 3;
					exp_rd.push_back(rd);
					exp_data.push_back(res);
					exp_test.push_back(tid);
					x[rd] = res;
				end
				prev_rd = wr ? rd : 5'd0;
			end
			exp_total = exp_rd.size();
			st_total  = st_adr.size();
		end
	endtask

	task automatic count_failure(int t);
		fails[t]++;
	endtask

	// ******************************************************************
	// checks on every rising edge on values sampled before the update
	// ******************************************************************
	always @(posedge clk) begin
		logic [4:0]  rd_e;
		logic [63:0] data_e;
		int          t;
		// outputs carry reset values once a reset edge has passed
		if (rst_q) begin
			checks++;
			assert (!ibus_cyc && !dbus_cyc && !commit_valid && !halted) else begin
				$display("reset state wrong: a bus cycle, commit or halt is active at reset");
				count_failure(1);
			end
		end
		if (!rst) begin
			if (ibus_cyc && !first_fetch) begin
				checks++;
				assert (ibus_adr == reset_pc) else begin
					$display("mismatch ibus_adr: got %h expected %h", ibus_adr, reset_pc);
					count_failure(1);
				end
			end
			if (commit_valid) begin
				commit_count++;
				checks++;
				assert (commit_rd != 5'd0) else begin
					$display("commit reported for x0");
					count_failure(3);
				end
				if (exp_rd.size() == 0) begin
					$display("commit of x%0d with no expected instruction left", commit_rd);
					count_failure(5);
				end else begin
					rd_e   = exp_rd.pop_front();
					data_e = exp_data.pop_front();
					t      = exp_test.pop_front();
					assert (commit_rd == rd_e) else begin
						$display("mismatch commit_rd: got %h expected %h", commit_rd, rd_e);
						count_failure(t);
					end
					assert (commit_data == data_e) else begin
						$display("mismatch commit_data: got %h expected %h",
							commit_data, data_e);
						count_failure(t);
					end
				end
			end
			if (dbus_cyc && dbus_stb && dbus_ack && dbus_we) begin
				store_count++;
				checks++;
				if (st_adr.size() == 0) begin
					$display("store on the data bus with no expected store left");
					count_failure(4);
				end else begin
					assert (dbus_adr == st_adr[0]) else begin
						$display("mismatch dbus_adr: got %h expected %h", dbus_adr, st_adr[0]);
						count_failure(4);
					end
					assert (dbus_dat_w == st_data[0]) else begin
						$display("mismatch dbus_dat_w: got %h expected %h",
							dbus_dat_w, st_data[0]);
						count_failure(4);
					end
					assert (dbus_sel == 8'hff) else begin
						$display("mismatch dbus_sel: got %h expected ff", dbus_sel);
						count_failure(4);
					end
					void'(st_adr.pop_front());
					void'(st_data.pop_front());
				end
			end
			// masters hold the request until ack
			if (i_req_q && ibus_stb) begin
				checks++;
				assert (ibus_adr == i_adr_q) else begin
					$display("mismatch ibus_adr: got %h expected %h", ibus_adr, i_adr_q);
					count_failure(5);
				end
			end
			if (d_req_q && dbus_stb) begin
				checks++;
				assert (dbus_adr == d_adr_q && dbus_dat_w == d_dat_q) else begin
					$display("mismatch dbus_adr/dbus_dat_w: got %h/%h expected %h/%h",
						dbus_adr, dbus_dat_w, d_adr_q, d_dat_q);
					count_failure(5);
				end
			end
			if (halted_q) begin
				checks++;
				assert (halted) else begin
					$display("halted dropped after it was raised");
					count_failure(6);
				end
				assert (!(ibus_cyc && !ibus_cyc_q)) else begin
					$display("instruction bus cycle started after halt");
					count_failure(6);
				end
			end
		end
		rst_q       <= rst;
		first_fetch <= !rst && (first_fetch || ibus_cyc);
		i_req_q     <= ibus_stb && !ibus_ack;
		i_adr_q     <= ibus_adr;
		d_req_q     <= dbus_stb && !dbus_ack;
		d_adr_q     <= dbus_adr;
		d_dat_q     <= dbus_dat_w;
		ibus_cyc_q  <= ibus_cyc;
		halted_q    <= !rst && halted;
	end

	// watchdog sized from the program length
	initial begin
		#(prog_len * 200 * 10);
		$display("watchdog expired before the program finished");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		void'($urandom(42));
		test_name[1] = "reset state";
		test_name[2] = "alu results";
		test_name[3] = "dependency chain";
		test_name[4] = "loads and stores";
		test_name[5] = "back-pressure";
		test_name[6] = "halt";
		for (int t = 1; t <= 6; t++)
			fails[t] = 0;
		checks       = 0;
		commit_count = 0;
		store_count  = 0;
		rst          = 1'b1;
		load_program();
		build_model();
		repeat (2) @(negedge clk);
		rst = 1'b0;
		// run until halted and everything before ebreak has drained
		while (!halted || commit_count < exp_total || store_count < st_total)
			@(negedge clk);
		// extra time for any stray commit or fetch
		repeat (20) @(negedge clk);
		checks++;
		assert (commit_count == exp_total) else begin
			$display("mismatch commit count: got %h expected %h", commit_count, exp_total);
			count_failure(6);
		end
		assert (store_count == st_total) else begin
			$display("mismatch store count: got %h expected %h", store_count, st_total);
			count_failure(4);
		end
		failed_tests = 0;
		for (int t = 1; t <= 6; t++) begin
			$display("test %0d %s: %s (%0d errors)", t, test_name[t],
				fails[t] == 0 ? "pass" : "fail", fails[t]);
			if (fails[t] != 0)
				failed_tests++;
		end
		$display("%0d tests passed, %0d failed, %0d checks run",
			6 - failed_tests, failed_tests, checks);
		if (failed_tests == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* tests/wb_memory_model.sv */
// dual-port wishbone slave memory that serves both core ports from one image
module wb_memory_model #(
	parameter int words = 512
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        ibus_cyc,
	input  logic        ibus_stb,
	input  logic [31:0] ibus_adr,
	output logic [31:0] ibus_dat_r,
	output logic        ibus_ack,
	input  logic        dbus_cyc,
	input  logic        dbus_stb,
	input  logic        dbus_we,
	input  logic [31:0] dbus_adr,
	input  logic [63:0] dbus_dat_w,
	input  logic [7:0]  dbus_sel,
	output logic [63:0] dbus_dat_r,
	output logic        dbus_ack
);
	// doubleword array where adr bits 2:0 are ignored
	logic [63:0] mem [words];
	int unsigned i_wait;
	int unsigned d_wait;

	// ******************************************************************
	// instruction port with 0 to 3 wait cycles per access
	// ******************************************************************
	always @(posedge clk) begin
		if (rst) begin
			ibus_ack   <= 1'b0;
			ibus_dat_r <= '0;
			i_wait     <= $urandom % 4;
		end else if (ibus_ack) begin
			// master drops cyc on this edge
			ibus_ack <= 1'b0;
			i_wait   <= $urandom % 4;
		end else if (ibus_cyc && ibus_stb) begin
			if (i_wait == 0) begin
				ibus_ack <= 1'b1;
				// upper or lower half of the doubleword
				if (ibus_adr[2])
					ibus_dat_r <= mem[ibus_adr[11:3]][63:32];
				else
					ibus_dat_r <= mem[ibus_adr[11:3]][31:0];
			end else begin
				i_wait <= i_wait - 1;
			end
		end
	end

	// ******************************************************************
	// data port honors byte lanes on writes
	// ******************************************************************
	always @(posedge clk) begin
		if (rst) begin
			dbus_ack   <= 1'b0;
			dbus_dat_r <= '0;
			d_wait     <= $urandom % 4;
		end else if (dbus_ack) begin
			dbus_ack <= 1'b0;
			d_wait   <= $urandom % 4;
		end else if (dbus_cyc && dbus_stb) begin
			if (d_wait == 0) begin
				dbus_ack   <= 1'b1;
				dbus_dat_r <= mem[dbus_adr[11:3]];
				if (dbus_we) begin
					for (int b = 0; b < 8; b++)
						if (dbus_sel[b])
							mem[dbus_adr[11:3]][b*8 +: 8] <= dbus_dat_w[b*8 +: 8];
				end
			end else begin
				d_wait <= d_wait - 1;
			end
		end
	end

endmodule

/* src/rv_core.sv */
// core top level, four-stage pipeline with instruction and data wishbone masters
module rv_core #(
	parameter rv_pkg::addr_t reset_pc = '0
) (
	input  logic             clk,
	input  logic             rst,
	output logic             ibus_cyc,
	output logic             ibus_stb,
	output rv_pkg::addr_t    ibus_adr,
	input  rv_pkg::inst_t    ibus_dat_r,
	input  logic             ibus_ack,
	output logic             dbus_cyc,
	output logic             dbus_stb,
	output logic             dbus_we,
	output rv_pkg::addr_t    dbus_adr,
	output rv_pkg::xlen_t    dbus_dat_w,
	output logic [7:0]       dbus_sel,
	input  rv_pkg::xlen_t    dbus_dat_r,
	input  logic             dbus_ack,
	output logic             commit_valid,
	output rv_pkg::reg_idx_t commit_rd,
	output rv_pkg::xlen_t    commit_data,
	output logic             halted
);
	import rv_pkg::*;

	// fetch -> decode
	logic     valid_if_id;
	logic     ready_if_id;
	inst_t    inst_if_id;

	// decode <-> register file
	reg_idx_t rs1;
	reg_idx_t rs2;
	xlen_t    rs1_data;
	xlen_t    rs2_data;
	logic     rs1_busy;
	logic     rs2_busy;
	logic     issue;
	reg_idx_t issue_rd;

	// decode -> execute
	logic     valid_id_ex;
	logic     ready_id_ex;
	alu_op_t  alu_op_id_ex;
	mem_op_t  mem_op_id_ex;
	xlen_t    a_id_ex;
	xlen_t    b_id_ex;
	xlen_t    store_id_ex;
	reg_idx_t rd_id_ex;
	logic     wen_id_ex;

	// execute -> memory
	logic     valid_ex_mem;
	logic     ready_ex_mem;
	xlen_t    result_ex_mem;
	xlen_t    store_ex_mem;
	mem_op_t  mem_op_ex_mem;
	reg_idx_t rd_ex_mem;
	logic     wen_ex_mem;

	// ******************************************************************
	// pipeline stages
	// ******************************************************************
	rv_fetch #(
		.reset_pc(reset_pc)
	) fetch_i (
		.clk(clk), .rst(rst), .halted(halted),
		.ibus_cyc(ibus_cyc), .ibus_stb(ibus_stb), .ibus_adr(ibus_adr),
		.ibus_dat_r(ibus_dat_r), .ibus_ack(ibus_ack),
		.out_valid(valid_if_id), .out_ready(ready_if_id),
		.out_pc(), .out_inst(inst_if_id)
	);

	rv_regfile regfile_i (
		.clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.rs1_busy(rs1_busy), .rs2_busy(rs2_busy),
		.issue(issue), .issue_rd(issue_rd),
		.wen(commit_valid), .wr_rd(commit_rd), .wr_data(commit_data)
	);

	rv_decode decode_i (
		.clk(clk), .rst(rst),
		.in_valid(valid_if_id), .in_ready(ready_if_id), .in_inst(inst_if_id),
		.rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.rs1_busy(rs1_busy), .rs2_busy(rs2_busy),
		.issue(issue), .issue_rd(issue_rd), .halted(halted),
		.out_valid(valid_id_ex), .out_ready(ready_id_ex),
		.out_alu_op(alu_op_id_ex), .out_mem_op(mem_op_id_ex),
		.out_a(a_id_ex), .out_b(b_id_ex), .out_store(store_id_ex),
		.out_rd(rd_id_ex), .out_wen(wen_id_ex)
	);

	rv_execute execute_i (
		.clk(clk), .rst(rst),
		.in_valid(valid_id_ex), .in_ready(ready_id_ex),
		.in_alu_op(alu_op_id_ex), .in_mem_op(mem_op_id_ex),
		.in_a(a_id_ex), .in_b(b_id_ex), .in_store(store_id_ex),
		.in_rd(rd_id_ex), .in_wen(wen_id_ex),
		.out_valid(valid_ex_mem), .out_ready(ready_ex_mem),
		.out_result(result_ex_mem), .out_store(store_ex_mem),
		.out_mem_op(mem_op_ex_mem), .out_rd(rd_ex_mem), .out_wen(wen_ex_mem)
	);

	// writeback registers double as the commit port
	rv_memory memory_i (
		.clk(clk), .rst(rst),
		.in_valid(valid_ex_mem), .in_ready(ready_ex_mem),
		.in_result(result_ex_mem), .in_store(store_ex_mem),
		.in_mem_op(mem_op_ex_mem), .in_rd(rd_ex_mem), .in_wen(wen_ex_mem),
		.dbus_cyc(dbus_cyc), .dbus_stb(dbus_stb), .dbus_we(dbus_we),
		.dbus_adr(dbus_adr), .dbus_dat_w(dbus_dat_w), .dbus_sel(dbus_sel),
		.dbus_dat_r(dbus_dat_r), .dbus_ack(dbus_ack),
		.wen(commit_valid), .wr_rd(commit_rd), .wr_data(commit_data)
	);

endmodule

/* src/rv_memory.sv */
// memory and writeback stage, data-bus master for ld/sd and the register write / commit
module rv_memory (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	output logic             in_ready,
	input  rv_pkg::xlen_t    in_result,
	input  rv_pkg::xlen_t    in_store,
	input  rv_pkg::mem_op_t  in_mem_op,
	input  rv_pkg::reg_idx_t in_rd,
	input  logic             in_wen,
	output logic             dbus_cyc,
	output logic             dbus_stb,
	output logic             dbus_we,
	output rv_pkg::addr_t    dbus_adr,
	output rv_pkg::xlen_t    dbus_dat_w,
	output logic [7:0]       dbus_sel,
	input  rv_pkg::xlen_t    dbus_dat_r,
	input  logic             dbus_ack,
	output logic             wen,
	output rv_pkg::reg_idx_t wr_rd,
	output rv_pkg::xlen_t    wr_data
);
	import rv_pkg::*;

	typedef enum logic {
		ms_idle,
		ms_bus
	} mem_state_t;

	mem_state_t state;
	logic       pend_wen;
	logic       fire;

	// one access at a time, next one accepted the cycle after ack
	assign in_ready = (state == ms_idle);
	assign fire     = in_valid && in_ready;

	assign dbus_cyc = (state == ms_bus);
	assign dbus_stb = (state == ms_bus);
	// doubleword only
	assign dbus_sel = 8'hff;

	// ******************************************************************
	// control, wen is a one-cycle pulse that doubles as commit_valid
	// ******************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ms_idle;
			wen   <= 1'b0;
		end else begin
			wen <= 1'b0;
			case (state)
			ms_idle: begin
				if (fire) begin
					if (in_mem_op == mem_none)
						wen <= in_wen;
					else
						state <= ms_bus;
				end
			end
			ms_bus: begin
				// stores carry pend_wen low
				if (dbus_ack) begin
					state <= ms_idle;
					wen   <= pend_wen;
				end
			end
			default: state <= ms_idle;
			endcase
		end
	end

	// bus request and writeback payload
	always_ff @(posedge clk) begin
		if (fire) begin
			dbus_adr   <= in_result[31:0];
			dbus_dat_w <= in_store;
			dbus_we    <= (in_mem_op == mem_store);
			pend_wen   <= in_wen && (in_mem_op == mem_load);
			wr_rd      <= in_rd;
			wr_data    <= in_result;
		end else if (state == ms_bus && dbus_ack) begin
			// load data lands here, committed the next cycle
			wr_data <= dbus_dat_r;
		end
	end

endmodule

/* src/rv_execute.sv */
// execute stage, alu result or effective address into the pipeline register
module rv_execute (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	output logic             in_ready,
	input  rv_pkg::alu_op_t  in_alu_op,
	input  rv_pkg::mem_op_t  in_mem_op,
	input  rv_pkg::xlen_t    in_a,
	input  rv_pkg::xlen_t    in_b,
	input  rv_pkg::xlen_t    in_store,
	input  rv_pkg::reg_idx_t in_rd,
	input  logic             in_wen,
	output logic             out_valid,
	input  logic             out_ready,
	output rv_pkg::xlen_t    out_result,
	output rv_pkg::xlen_t    out_store,
	output rv_pkg::mem_op_t  out_mem_op,
	output rv_pkg::reg_idx_t out_rd,
	output logic             out_wen
);
	import rv_pkg::*;

	xlen_t alu_out;
	logic  fire;

	// ld/sd use alu_add for the address
	always_comb begin
		case (in_alu_op)
		alu_add:    alu_out = in_a + in_b;
		alu_sub:    alu_out = in_a - in_b;
		alu_and:    alu_out = in_a & in_b;
		alu_or:     alu_out = in_a | in_b;
		alu_xor:    alu_out = in_a ^ in_b;
		alu_pass_b: alu_out = in_b;
		default:    alu_out = '0;
		endcase
	end

	// accept when the register is empty or draining this cycle
	assign in_ready = !out_valid || out_ready;
	assign fire     = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else if (fire)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			out_result <= alu_out;
			out_store  <= in_store;
			out_mem_op <= in_mem_op;
			out_rd     <= in_rd;
			out_wen    <= in_wen;
		end
	end

endmodule

/* src/rv_decode.sv */
// decode stage, splits fields, reads operands, stalls on busy sources and halts on ebreak
module rv_decode (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	output logic             in_ready,
	input  rv_pkg::inst_t    in_inst,
	output rv_pkg::reg_idx_t rs1,
	output rv_pkg::reg_idx_t rs2,
	input  rv_pkg::xlen_t    rs1_data,
	input  rv_pkg::xlen_t    rs2_data,
	input  logic             rs1_busy,
	input  logic             rs2_busy,
	output logic             issue,
	output rv_pkg::reg_idx_t issue_rd,
	output logic             halted,
	output logic             out_valid,
	input  logic             out_ready,
	output rv_pkg::alu_op_t  out_alu_op,
	output rv_pkg::mem_op_t  out_mem_op,
	output rv_pkg::xlen_t    out_a,
	output rv_pkg::xlen_t    out_b,
	output rv_pkg::xlen_t    out_store,
	output rv_pkg::reg_idx_t out_rd,
	output logic             out_wen
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t   rd;
	xlen_t      imm_i;
	xlen_t      imm_s;
	xlen_t      imm_u;

	// decoded controls
	alu_op_t dec_alu;
	mem_op_t dec_mem;
	xlen_t   dec_imm;
	logic    use_imm;
	logic    use_rs1;
	logic    use_rs2;
	logic    writes;
	logic    r_type;
	logic    is_ebreak;
	logic    hazard;
	logic    fire;

	assign opcode = in_inst[6:0];
	assign rd     = in_inst[11:7];
	assign funct3 = in_inst[14:12];
	assign funct7 = in_inst[31:25];
	assign rs1    = in_inst[19:15];
	assign rs2    = in_inst[24:20];

	// sign-extended immediates
	assign imm_i = {{52{in_inst[31]}}, in_inst[31:20]};
	assign imm_s = {{52{in_inst[31]}}, in_inst[31:25], in_inst[11:7]};
	assign imm_u = {{32{in_inst[31]}}, in_inst[31:12], 12'b0};

	// ******************************************************************
	// opcode decode, anything unknown becomes a bubble with no write
	// ******************************************************************
	always_comb begin
		dec_alu   = alu_add;
		dec_mem   = mem_none;
		dec_imm   = imm_i;
		use_imm   = 1'b1;
		use_rs1   = 1'b0;
		use_rs2   = 1'b0;
		writes    = 1'b0;
		r_type    = 1'b0;
		is_ebreak = 1'b0;
		case (opcode)
		opc_op_imm: begin
			// addi only
			use_rs1 = (funct3 == f3_add);
			writes  = (funct3 == f3_add);
		end
		opc_op: begin
			if (funct7 == f7_base || (funct7 == f7_sub && funct3 == f3_add)) begin
				case (funct3)
				f3_add: begin
					dec_alu = funct7[5] ? alu_sub : alu_add;
					r_type  = 1'b1;
				end
				f3_xor: begin
					dec_alu = alu_xor;
					r_type  = 1'b1;
				end
				f3_or: begin
					dec_alu = alu_or;
					r_type  = 1'b1;
				end
				f3_and: begin
					dec_alu = alu_and;
					r_type  = 1'b1;
				end
				default: r_type = 1'b0;
				endcase
			end
			use_imm = 1'b0;
			use_rs1 = r_type;
			use_rs2 = r_type;
			writes  = r_type;
		end
		opc_lui: begin
			dec_alu = alu_pass_b;
			dec_imm = imm_u;
			writes  = 1'b1;
		end
		opc_load: begin
			// ld, address = rs1 + imm_i
			if (funct3 == f3_double) begin
				dec_mem = mem_load;
				use_rs1 = 1'b1;
				writes  = 1'b1;
			end
		end
		opc_store: begin
			if (funct3 == f3_double) begin
				dec_mem = mem_store;
				dec_imm = imm_s;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
		end
		opc_system: is_ebreak = (in_inst == inst_ebreak);
		default: writes = 1'b0;
		endcase
	end

	// stall only on sources actually read
	assign hazard   = (use_rs1 && rs1_busy) || (use_rs2 && rs2_busy);
	assign in_ready = !halted && !hazard && (!out_valid || out_ready);
	assign fire     = in_valid && in_ready;

	// claim rd in the scoreboard as the instruction leaves decode
	assign issue    = fire && writes && (rd != '0);
	assign issue_rd = rd;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			halted    <= 1'b0;
		end else begin
			if (fire && is_ebreak)
				halted <= 1'b1;
			if (fire && !is_ebreak)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	// output payload
	always_ff @(posedge clk) begin
		if (fire && !is_ebreak) begin
			out_alu_op <= dec_alu;
			out_mem_op <= dec_mem;
			out_a      <= rs1_data;
			out_b      <= use_imm ? dec_imm : rs2_data;
			out_store  <= rs2_data;
			out_rd     <= rd;
			out_wen    <= writes && (rd != '0);
		end
	end

endmodule

/* src/rv_regfile.sv */
// general register file with two combinational read ports and the busy scoreboard
module rv_regfile (
	input  logic             clk,
	input  logic             rst,
	input  rv_pkg::reg_idx_t rs1,
	input  rv_pkg::reg_idx_t rs2,
	output rv_pkg::xlen_t    rs1_data,
	output rv_pkg::xlen_t    rs2_data,
	output logic             rs1_busy,
	output logic             rs2_busy,
	input  logic             issue,
	input  rv_pkg::reg_idx_t issue_rd,
	input  logic             wen,
	input  rv_pkg::reg_idx_t wr_rd,
	input  rv_pkg::xlen_t    wr_data
);
	import rv_pkg::*;

	// x1..x31, x0 is synthesized as zero
	xlen_t regs [1:31];

	// outstanding writes per register, up to four in flight
	logic [2:0]  pending [32];
	logic [31:0] busy;
	logic [31:0] set_vec;
	logic [31:0] clr_vec;

	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];
	assign rs1_busy = busy[rs1];
	assign rs2_busy = busy[rs2];

	always_comb begin
		for (int i = 0; i < 32; i++) begin
			busy[i]    = (pending[i] != 3'd0);
			// x0 never tracked
			set_vec[i] = issue && (issue_rd == reg_idx_t'(i)) && (i != 0);
			clr_vec[i] = wen && (wr_rd == reg_idx_t'(i)) && (i != 0);
		end
	end

	// ******************************************************************
	// scoreboard
	// a count per register keeps an older write from clearing a newer claim
	// ******************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				pending[i] <= 3'd0;
		end else begin
			for (int i = 0; i < 32; i++) begin
				// set and clear together leave it busy
				if (set_vec[i] && !clr_vec[i])
					pending[i] <= pending[i] + 3'd1;
				else if (clr_vec[i] && !set_vec[i])
					pending[i] <= pending[i] - 3'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wen && wr_rd != '0)
			regs[wr_rd] <= wr_data;
	end

endmodule

/* src/rv_fetch.sv */
// instruction fetch stage, runs one wishbone read per pc and hands the word to decode
module rv_fetch #(
	parameter rv_pkg::addr_t reset_pc = '0
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           halted,
	output logic           ibus_cyc,
	output logic           ibus_stb,
	output rv_pkg::addr_t  ibus_adr,
	input  rv_pkg::inst_t  ibus_dat_r,
	input  logic           ibus_ack,
	output logic           out_valid,
	input  logic           out_ready,
	output rv_pkg::addr_t  out_pc,
	output rv_pkg::inst_t  out_inst
);
	import rv_pkg::*;

	// idle -> bus on start, bus -> hold on ack, hold -> idle once decode takes it
	typedef enum logic [1:0] {
		st_idle,
		st_bus,
		st_hold
	} fetch_state_t;

	fetch_state_t state;

	// bus strobes come straight from the state register
	assign ibus_cyc  = (state == st_bus);
	assign ibus_stb  = (state == st_bus);
	assign ibus_adr  = out_pc;
	assign out_valid = (state == st_hold);

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= st_idle;
			out_pc <= reset_pc;
		end else begin
			case (state)
			st_idle: begin
				// no new cycle after ebreak
				if (!halted)
					state <= st_bus;
			end
			st_bus: begin
				if (ibus_ack)
					state <= st_hold;
			end
			st_hold: begin
				// pc moves only when decode accepts
				if (out_ready) begin
					state  <= st_idle;
					out_pc <= out_pc + addr_t'(4);
				end
			end
			default: state <= st_idle;
			endcase
		end
	end

	// instruction word latch
	always_ff @(posedge clk) begin
		if (state == st_bus && ibus_ack)
			out_inst <= ibus_dat_r;
	end

endmodule

/* src/rv_pkg.sv */
// shared widths, opcode constants and operation enums, imported by every core stage
package rv_pkg;

	// ******************************************************************
	// widths that carry a meaning
	// ******************************************************************
	typedef logic [63:0] xlen_t;
	typedef logic [31:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_idx_t;

	// alu function, pass_b feeds lui immediate through
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b
	} alu_op_t;

	typedef enum logic [1:0] {
		mem_none,
		mem_load,
		mem_store
	} mem_op_t;

	// ******************************************************************
	// major opcodes
	// ******************************************************************
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_system = 7'b1110011;

	// funct3 / funct7 values
	localparam logic [2:0] f3_add    = 3'b000;
	localparam logic [2:0] f3_xor    = 3'b100;
	localparam logic [2:0] f3_or     = 3'b110;
	localparam logic [2:0] f3_and    = 3'b111;
	localparam logic [2:0] f3_double = 3'b011;
	localparam logic [6:0] f7_base   = 7'b0000000;
	localparam logic [6:0] f7_sub    = 7'b0100000;

	// full ebreak encoding
	localparam inst_t inst_ebreak = 32'h0010_0073;

endpackage
